/* cpu_ctl_defs.svh */
// Widths and field sizes of the bus and control word, included by the package and every RTL file
`ifndef CPU_CTL_DEFS_SVH
`define CPU_CTL_DEFS_SVH

// Data bus
`define CTL_DB_W        8       // Data bus and opcode width
`define CTL_DB_SIGN     7       // Sign bit of a branch offset

// Sequencer
`define CTL_STATE_W     6       // Instruction state code

// Address bus operation, {hold, abl_sel, abh_sel, abl_ci}
`define CTL_AB_OP_W     12
`define CTL_AB_HOLD_W   7       // PC / AHL / ABH hold field on top
`define CTL_ABH_SEL_W   2       // ABH source select
`define CTL_MODE_W      4       // Compressed address mode

// ALU operation, {ldm, bcd, shift, add, carry}
`define CTL_ALU_OP_W    9
`define CTL_SHIFT_W     2
`define CTL_ADD_W       3
`define CTL_CARRY_W     2

// Register operation, {write, dst, src}
`define CTL_REG_OP_W    7
`define CTL_DST_W       2
`define CTL_SRC_W       4

// Data-out select
`define CTL_DO_OP_W     2

`endif

/* cpu_ctl_pkg.sv */
// Shared types of the control unit: state, address mode, ALU and register enums, decode and control structs
`include "cpu_ctl_defs.svh"

package cpu_ctl_pkg;

    // Instruction states of the sequencer
    typedef enum logic [`CTL_STATE_W-1:0] {
        INIT, SYNC, BACK, IMM0,     // Start, opcode fetch, final read, immediate
        IND0, IND1, IND2,           // Zero-page indirection
        ABS0, ABS1,                 // Absolute address low / high
        ZERO, RDWR,                 // Zero-page access, modify cycle
        PULL, PUSH,
        RTS0, RTS1, RTS2,
        JSR0, JSR1, JSR2,
        COND                        // Branch offset
    } ctl_state_e;

    // Address datapath modes, code values match the AB datapath table
    typedef enum logic [`CTL_MODE_W-1:0] {
        AB_KEEP     = 4'b0000,      // AB unchanged
        AB_PC       = 4'b0001,      // Back to stored PC
        AB_IDX16    = 4'b0010,      // {DB, AHL + reg}, store PC
        AB_ZP_IDX   = 4'b0011,      // {00, DB + reg}
        AB_INC      = 4'b0100,      // AB + 1, store PC
        AB_SP_INC   = 4'b0101,      // {01, SP + 1}
        AB_BRANCH   = 4'b0111,      // AB + offset + 1
        AB_SP       = 4'b1000,      // {01, SP}, keep PC
        AB_SP_PC    = 4'b1001,      // {01, SP}, store PC + 1
        AB_IDX_KEEP = 4'b1010,      // {DB, AHL + reg}, keep PC
        AB_SP_POP   = 4'b1011,      // {01, SP}, hold AHL
        AB_INC_KEEP = 4'b1100,      // AB + 1, keep PC
        AB_IDX_INC  = 4'b1110,      // {DB, AHL + reg} + 1
        AB_VECTOR   = 4'b1111       // {FF, vector} + 1
    } ab_mode_e;

    // Adder operations of the ALU
    typedef enum logic [`CTL_ADD_W-1:0] {
        ALU_OR, ALU_AND, ALU_XOR, ALU_ADD, ALU_INC, ALU_DEC, ALU_SUB, ALU_TRB
    } alu_add_e;

    // Register file indices
    typedef enum logic [`CTL_SRC_W-1:0] {
        REG_X = 4'd0,
        REG_Y = 4'd1,
        REG_A = 4'd2,
        REG_S = 4'd3,
        REG_Z = 4'd7                // Reads as zero
    } reg_idx_e;

    typedef struct packed {
        logic [`CTL_SHIFT_W-1:0] shift;     // 10 left, 11 right
        alu_add_e                add;
        logic [`CTL_CARRY_W-1:0] carry;     // 01 one, 10 rotate, 11 adc
    } alu_t;

    // Flags latched at opcode fetch
    typedef struct packed {
        logic                  rmw;         // Hold address for modify cycle
        logic                  jmp;         // Absolute address is a jump target
        logic                  ind;         // One more 16-bit indirection
        logic                  add_x;
        logic                  add_y;
        logic                  ld;          // Register write at next sync
        logic [`CTL_DST_W-1:0] dst;
        logic [`CTL_SRC_W-1:0] src;
        alu_t                  alu;
    } decode_t;

    // Control word to the datapath
    typedef struct packed {
        logic [`CTL_AB_OP_W-1:0]  ab_op;
        logic [`CTL_ALU_OP_W-1:0] alu_op;
        logic [`CTL_REG_OP_W-1:0] reg_op;
        logic [`CTL_DO_OP_W-1:0]  do_op;
        logic                     we;
    } ctl_word_t;

endpackage

/* opcode_decoder.sv */
// Opcode decoder of the control unit, latches per-instruction flags from the data bus at each sync
`timescale 1ns/1ps
`include "cpu_ctl_defs.svh"

module opcode_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sync,        // Opcode on db this cycle
    input  logic                 flag_clear,  // ABS1, indirection used up
    input  logic [`CTL_DB_W-1:0] db,
    output cpu_ctl_pkg::decode_t dec
);
    import cpu_ctl_pkg::*;

    decode_t op_dec;                          // Flags for the byte now on db

    // Destination field is the low bits of the register index
    function automatic logic [`CTL_DST_W-1:0] dst_of(input reg_idx_e r);
        return r[`CTL_DST_W-1:0];
    endfunction

    function automatic alu_t alu_of(input alu_add_e add, input logic [`CTL_CARRY_W-1:0] carry);
        alu_t a;
        a.shift = '0;                         // No shift for kept opcodes
        a.add   = add;
        a.carry = carry;
        return a;
    endfunction

    always_comb begin
        op_dec     = '0;
        op_dec.src = REG_Z;                   // Loads take M + 0

        // Sequencing flags
        case (db)
            8'h06: op_dec.rmw = 1'b1;         // ASL ZP
            8'h20, 8'h4C, 8'h60: op_dec.jmp = 1'b1;  // JSR, JMP abs, RTS
            8'h6C, 8'h7C: begin               // JMP (ind), JMP (ind,X)
                op_dec.jmp = 1'b1;
                op_dec.ind = 1'b1;
            end
            default: ;
        endcase

        // Index registers
        case (db)
            8'h7C, 8'hB5, 8'hBD, 8'hA1: op_dec.add_x = 1'b1;
            8'hB1, 8'hB6, 8'hB9: op_dec.add_y = 1'b1;
            default: ;
        endcase

        // Register write, ld stays 0 for anything else
        case (db)
            8'hA9, 8'hA5, 8'hB5, 8'hAD, 8'hBD,
            8'hB9, 8'hA1, 8'hB2, 8'hB1: begin // LDA, all modes
                op_dec.ld  = 1'b1;
                op_dec.dst = dst_of(REG_A);
                op_dec.alu = alu_of(ALU_ADD, 2'b00);
            end
            8'hA2, 8'hB6: begin               // LDX #imm, LDX zp,Y
                op_dec.ld  = 1'b1;
                op_dec.dst = dst_of(REG_X);
                op_dec.alu = alu_of(ALU_ADD, 2'b00);
            end
            8'hA0: begin                      // LDY #imm
                op_dec.ld  = 1'b1;
                op_dec.dst = dst_of(REG_Y);
                op_dec.alu = alu_of(ALU_ADD, 2'b00);
            end
            8'hCA: begin                      // DEX
                op_dec.ld  = 1'b1;
                op_dec.dst = dst_of(REG_X);
                op_dec.src = REG_X;
                op_dec.alu = alu_of(ALU_DEC, 2'b00);
            end
            8'hE8: begin                      // INX, carry in 1
                op_dec.ld  = 1'b1;
                op_dec.dst = dst_of(REG_X);
                op_dec.src = REG_X;
                op_dec.alu = alu_of(ALU_INC, 2'b01);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec <= '0;
        end else if (sync) begin
            dec <= op_dec;                    // New instruction
        end else if (flag_clear) begin
            dec.ind   <= 1'b0;                // Stop looping indirections
            dec.add_x <= 1'b0;                // Index applied once for (ind,X)
        end
    end

endmodule

/* ctl_sequencer.sv */
// Instruction state machine of the control unit, dispatches on the opcode and flags sync cycles
`timescale 1ns/1ps
`include "cpu_ctl_defs.svh"

module ctl_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CTL_DB_W-1:0]    db,
    input  cpu_ctl_pkg::decode_t    dec,
    output cpu_ctl_pkg::ctl_state_e state,
    output logic                    sync,
    output logic                    flag_clear
);
    import cpu_ctl_pkg::*;

    ctl_state_e state_nxt;

    assign sync       = (state == SYNC);      // Opcode fetch cycle
    assign flag_clear = (state == ABS1);      // High byte of absolute address

    // Opcode dispatch and per-sequence stepping
    always_comb begin
        case (state)
            INIT: state_nxt = SYNC;
            SYNC: begin
                case (db)
                    8'h80: state_nxt = COND;  // BRA
                    8'h20: state_nxt = JSR0;  // JSR
                    8'h60: state_nxt = RTS0;  // RTS
                    8'h4C, 8'h6C, 8'h7C: state_nxt = ABS0;  // JMP abs / ind / ind,X
                    8'h06: state_nxt = ZERO;  // ASL zp
                    8'hA5, 8'hB5, 8'hB6: state_nxt = ZERO;  // Zero-page loads
                    8'hA1, 8'hB2, 8'hB1: state_nxt = IND0;  // Indirect loads
                    8'hAD, 8'hBD, 8'hB9: state_nxt = ABS0;  // Absolute loads
                    8'hA9, 8'hA0, 8'hA2: state_nxt = IMM0;  // Immediate loads
                    8'h48: state_nxt = PUSH;
                    8'h68: state_nxt = PULL;
                    default: state_nxt = SYNC;  // Undefined or single-cycle, fetch again
                endcase
            end
            IMM0: state_nxt = SYNC;
            IND0: state_nxt = IND1;
            IND1: state_nxt = IND2;
            IND2: state_nxt = BACK;
            ABS0: state_nxt = ABS1;
            ABS1: begin
                if (dec.ind) begin
                    state_nxt = ABS0;         // Fetch the pointed-to address
                end else if (dec.jmp) begin
                    state_nxt = SYNC;         // AB already at target
                end else begin
                    state_nxt = BACK;
                end
            end
            ZERO: state_nxt = dec.rmw ? RDWR : BACK;
            RDWR: state_nxt = BACK;
            BACK: state_nxt = SYNC;
            PULL: state_nxt = BACK;
            PUSH: state_nxt = BACK;
            RTS0: state_nxt = RTS1;
            RTS1: state_nxt = RTS2;
            RTS2: state_nxt = SYNC;
            JSR0: state_nxt = JSR1;
            JSR1: state_nxt = JSR2;
            JSR2: state_nxt = ABS1;           // Target high byte, jmp set
            COND: state_nxt = SYNC;
            default: state_nxt = INIT;        // Unused codes restart
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= INIT;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

/* ctl_encoder.sv */
// Control word encoder that the top instantiates to turn state and decoded flags into datapath fields
`timescale 1ns/1ps
`include "cpu_ctl_defs.svh"

module ctl_encoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cpu_ctl_pkg::ctl_state_e state,
    input  cpu_ctl_pkg::decode_t    dec,
    input  logic                    cond,     // Branch taken
    input  logic [`CTL_DB_W-1:0]    db,
    output cpu_ctl_pkg::ctl_word_t  ctl
);
    import cpu_ctl_pkg::*;

    // Data-out sources
    localparam logic [`CTL_DO_OP_W-1:0] DO_ALU = 2'b00;
    localparam logic [`CTL_DO_OP_W-1:0] DO_PCL = 2'b10;
    localparam logic [`CTL_DO_OP_W-1:0] DO_PCH = 2'b11;

    // Fixed ALU words as {ldm, bcd, shift, add, carry}
    localparam logic [`CTL_ALU_OP_W-1:0] ALU_OP_DEC = {4'b0000, ALU_DEC, 2'b00};
    localparam logic [`CTL_ALU_OP_W-1:0] ALU_OP_INC = {4'b0000, ALU_INC, 2'b01};
    localparam logic [`CTL_ALU_OP_W-1:0] ALU_OP_LDM = {4'b1000, ALU_OR, 2'b00};

    ab_mode_e                    mode;
    logic [`CTL_AB_HOLD_W-1:0]   hold;
    logic [`CTL_ABH_SEL_W-1:0]   abh_sel;
    logic [`CTL_AB_OP_W-1:0]     ab_op;
    logic [`CTL_ALU_OP_W-1:0]    alu_op;
    logic [`CTL_REG_OP_W-1:0]    reg_op;
    logic [`CTL_DO_OP_W-1:0]     do_op;
    logic                        we;
    logic                        back;

    // Read-only register select with write bit and dst clear
    function automatic logic [`CTL_REG_OP_W-1:0] idx_op(input reg_idx_e r);
        return {1'b0, 2'b00, r};
    endfunction

    assign back = cond & db[`CTL_DB_SIGN];    // Taken backward branch

    always_comb begin
        case (state)
            INIT, RDWR:     mode = AB_KEEP;
            BACK, JSR2:     mode = AB_PC;
            SYNC, ABS0:     mode = AB_INC;
            IMM0:           mode = AB_INC;
            ABS1:           mode = AB_IDX16;
            IND0, ZERO:     mode = AB_ZP_IDX;
            IND1:           mode = AB_INC_KEEP;
            IND2:           mode = AB_IDX_KEEP;
            PULL:           mode = AB_SP_INC;
            PUSH:           mode = AB_SP_POP;
            RTS0, RTS1:     mode = AB_SP_INC;
            RTS2:           mode = AB_IDX_INC;
            JSR0:           mode = AB_SP_PC;
            JSR1:           mode = AB_SP;
            COND:           mode = AB_BRANCH;
            default:        mode = AB_KEEP;
        endcase
    end

    // Low bits of mode go straight to ABL select and carry
    always_comb begin
        case (mode)
            AB_KEEP:     {hold, abh_sel} = {7'b001_0110, 2'b11};
            AB_PC:       {hold, abh_sel} = {7'b000_1010, 2'b10};
            AB_IDX16:    {hold, abh_sel} = {7'b111_1110, 2'b01};
            AB_ZP_IDX:   {hold, abh_sel} = {7'b111_0000, 2'b01};  // ABH forced 00
            AB_INC:      {hold, abh_sel} = {7'b011_0110, 2'b11};
            AB_SP_INC:   {hold, abh_sel} = {7'b011_0001, 2'b00};
            AB_BRANCH: begin
                if (back) begin
                    {hold, abh_sel} = {7'b011_0111, 2'b11};        // ABH gets FF
                end else begin
                    {hold, abh_sel} = {7'b011_0110, 2'b11};        // Forward or not taken
                end
            end
            AB_SP:       {hold, abh_sel} = {7'b000_0001, 2'b00};
            AB_SP_PC:    {hold, abh_sel} = {7'b111_0001, 2'b00};
            AB_IDX_KEEP: {hold, abh_sel} = {7'b001_1110, 2'b01};
            AB_SP_POP:   {hold, abh_sel} = {7'b010_0001, 2'b00};
            AB_INC_KEEP: {hold, abh_sel} = {7'b001_0110, 2'b11};
            AB_IDX_INC:  {hold, abh_sel} = {7'b001_1110, 2'b01};
            default:     {hold, abh_sel} = '0;
        endcase
        ab_op = {hold, mode[1:0], abh_sel, mode[2]};
    end

    always_comb begin
        case (state)
            JSR0, JSR1, RTS0, RTS1: reg_op = {1'b1, 2'b11, REG_S};  // S written back
            IND0:    reg_op = dec.add_x ? idx_op(REG_X) : idx_op(REG_Z);
            IND2:    reg_op = dec.add_y ? idx_op(REG_Y) : idx_op(REG_Z);
            ZERO, ABS1: begin
                if (dec.add_x) begin
                    reg_op = idx_op(REG_X);
                end else if (dec.add_y) begin
                    reg_op = idx_op(REG_Y);
                end else begin
                    reg_op = idx_op(REG_Z);
                end
            end
            SYNC:    reg_op = {dec.ld, dec.dst, dec.src};   // dst <= src op M
            default: reg_op = idx_op(REG_Z);
        endcase
    end

    always_comb begin
        case (state)
            JSR0, JSR1: alu_op = ALU_OP_DEC;  // Stack pointer down
            RTS0, RTS1: alu_op = ALU_OP_INC;  // Stack pointer up
            IMM0, BACK: alu_op = ALU_OP_LDM;
            SYNC:       alu_op = {2'b00, dec.alu};
            default:    alu_op = '0;
        endcase
    end

    always_comb begin
        case (state)
            JSR1:    do_op = DO_PCH;          // Return address high first
            JSR2:    do_op = DO_PCL;
            default: do_op = DO_ALU;
        endcase
    end

    // Write strobe for the two JSR stack pushes one cycle late
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we <= 1'b0;
        end else begin
            we <= (state == JSR0) || (state == JSR1);
        end
    end

    assign ctl = '{ab_op: ab_op, alu_op: alu_op, reg_op: reg_op, do_op: do_op, we: we};

endmodule

/* cpu_ctl.sv */
// Top of the 65C02 control unit, connects opcode decoder, state sequencer and control encoder
`timescale 1ns/1ps
`include "cpu_ctl_defs.svh"

module cpu_ctl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CTL_DB_W-1:0]   db,
    input  logic                   cond,
    output logic                   sync,
    output cpu_ctl_pkg::ctl_word_t ctl
);
    import cpu_ctl_pkg::*;

    ctl_state_e state;                        // Current instruction cycle
    decode_t    dec;                          // Flags of the running instruction
    logic       flag_clear;

    opcode_decoder opcode_decoder_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sync       (sync),
        .flag_clear (flag_clear),
        .db         (db),
        .dec        (dec)
    );

    ctl_sequencer ctl_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .db         (db),
        .dec        (dec),
        .state      (state),
        .sync       (sync),
        .flag_clear (flag_clear)
    );

    ctl_encoder ctl_encoder_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state),
        .dec   (dec),
        .cond  (cond),
        .db    (db),
        .ctl   (ctl)
    );

endmodule

/* cpu_ctl_assert.sv */
// Concurrent checks on sync, the JSR write strobe and the reset state that bind attaches to cpu_ctl
`timescale 1ns/1ps

module cpu_ctl_assert (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    sync,
    input cpu_ctl_pkg::ctl_state_e state,
    input cpu_ctl_pkg::ctl_word_t  ctl
);
    import cpu_ctl_pkg::*;

    int failures = 0;                         // Assertion failures so far

    // Opcode fetch pulse follows the state
    sync_is_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        sync == (state == SYNC))
        else begin
            failures++;
            $error("sync differs from the SYNC state");
        end

    // Stack writes only one cycle after a JSR push state
    we_after_jsr: assert property (@(posedge clk) disable iff (!rst_n)
        ctl.we |-> $past(state == JSR0 || state == JSR1))
        else begin
            failures++;
            $error("we high outside the JSR stack writes");
        end

    reset_release: assert property (@(posedge clk)
        $rose(rst_n) |-> (state == INIT) && !ctl.we)
        else begin
            failures++;
            $error("state not INIT or we high after reset release");
        end

endmodule

bind cpu_ctl cpu_ctl_assert cpu_ctl_assert_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .sync  (sync),
    .state (state),
    .ctl   (ctl)
);

/* cpu_ctl_tb.sv */
// Top-level directed testbench that drives the control unit with opcodes and checks its outputs
`timescale 1ns/1ps
`include "cpu_ctl_defs.svh"

module cpu_ctl_tb;
    import cpu_ctl_pkg::*;

    localparam int TEST_CYCLES = 400;                 // Covers reset, all 256 opcodes and field tests
    localparam int MAX_CYCLES  = TEST_CYCLES + 100;   // Plus margin
    localparam int FEED_LIMIT  = 16;                  // Longest sequence is 5 cycles
    localparam logic [`CTL_DO_OP_W-1:0] DO_PCL = 2'b10;
    localparam logic [`CTL_DO_OP_W-1:0] DO_PCH = 2'b11;

    logic                 clk;
    logic                 rst_n;
    logic [`CTL_DB_W-1:0] db;
    logic                 cond;
    logic                 sync;
    ctl_word_t            ctl;

    integer    seed = 6;
    int        errors = 0;
    int        checks = 0;
    int        assert_failures = 0;
    int        cycle_count = 0;
    ctl_word_t trace [$];                             // ctl per cycle of the last instruction

    cpu_ctl cpu_ctl_inst (.clk(clk), .rst_n(rst_n), .db(db), .cond(cond),
                          .sync(sync), .ctl(ctl));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                       // 40 ns period
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout, tests still running after %0d cycles", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    // {hold, ABL select, ABH select, carry} as the mode table expands it
    function automatic logic [`CTL_AB_OP_W-1:0] ab_word(input logic [6:0] hold,
                                                        input logic [1:0] abh, input ab_mode_e mode);
        logic [3:0] m;
        m = mode;
        return {hold, m[1:0], abh, m[2]};
    endfunction

    function automatic logic [`CTL_ALU_OP_W-1:0] alu_word(input logic ldm, input alu_add_e add,
                                                          input logic [1:0] carry);
        return {ldm, 1'b0, 2'b00, add, carry};        // No BCD and no shift
    endfunction

    function automatic logic [`CTL_REG_OP_W-1:0] reg_word(input logic wr, input reg_idx_e dst,
                                                          input reg_idx_e src);
        logic [3:0] d;
        d = dst;
        return {wr, d[1:0], src};
    endfunction

    // Sync-to-sync lengths of the kept instructions
    function automatic int expected_cycles(input logic [7:0] op);
        case (op)
            8'hA9, 8'hA2, 8'hA0, 8'h80:                 return 2;
            8'hA5, 8'hB5, 8'hB6, 8'h48, 8'h68, 8'h4C:   return 3;
            8'h06, 8'hAD, 8'hBD, 8'hB9, 8'h60:          return 4;
            8'hA1, 8'hB2, 8'hB1, 8'h6C, 8'h7C, 8'h20:   return 5;
            default:                                    return 1;  // Undefined opcodes refetch
        endcase
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // A b7 of -1 keeps the random bit 7 while 0 or 1 forces it
    task automatic filler_byte(input int b7, output logic [7:0] b);
        b = $random(seed);
        if (b7 == 0) b[7] = 1'b0;
        else if (b7 == 1) b[7] = 1'b1;
    endtask

    // Runs from 2 ns into a sync cycle to 2 ns into the next one
    task automatic feed_opcode(input logic [7:0] op, input int b7, output int cycles);
        logic [7:0] fill;
        trace.delete();
        db = op;
        @(negedge clk);
        trace.push_back(ctl);                         // Opcode fetch cycle
        cycles = 1;
        @(posedge clk);
        #2;
        while (!sync && cycles < FEED_LIMIT) begin
            filler_byte(b7, fill);
            db = fill;                                // Operand or data byte
            @(negedge clk);
            trace.push_back(ctl);
            cycles++;
            @(posedge clk);
            #2;
        end
        assert (sync) else begin
            errors++;
            $display("Opcode %02h did not return to sync within %0d cycles", op, FEED_LIMIT);
        end
    endtask

    task automatic reset_start();
        @(negedge clk);                               // INIT cycle
        expect_equal("reset sync", 0, sync);
        expect_equal("reset ab_op", ab_word(7'b001_0110, 2'b11, AB_KEEP), ctl.ab_op);
        expect_equal("reset we", 0, ctl.we);
        @(posedge clk);
        #2;
        expect_equal("reset first sync", 1, sync);
    endtask

    task automatic instruction_lengths();
        int cycles;
        for (int op = 0; op < 256; op++) begin
            feed_opcode(op[7:0], -1, cycles);
            expect_equal($sformatf("length %02h", op), expected_cycles(op[7:0]), cycles);
        end
    endtask

    task automatic write_check(input string name, input logic [7:0] op,
                               input logic [6:0] reg_exp, input logic [8:0] alu_exp);
        int cycles;
        feed_opcode(op, -1, cycles);
        feed_opcode(8'hEA, -1, cycles);               // Its sync shows the previous flags
        expect_equal({name, " reg_op"}, reg_exp, trace[0].reg_op);
        expect_equal({name, " alu_op"}, alu_exp, trace[0].alu_op);
    endtask

    task automatic no_write_check(input string name, input logic [7:0] op);
        int cycles;
        feed_opcode(op, -1, cycles);
        feed_opcode(8'hEA, -1, cycles);
        expect_equal({name, " write bit"}, 0, trace[0].reg_op[6]);
    endtask

    task automatic register_writes();
        write_check("LDA imm", 8'hA9, reg_word(1'b1, REG_A, REG_Z), alu_word(0, ALU_ADD, 2'b00));
        write_check("LDX imm", 8'hA2, reg_word(1'b1, REG_X, REG_Z), alu_word(0, ALU_ADD, 2'b00));
        write_check("LDY imm", 8'hA0, reg_word(1'b1, REG_Y, REG_Z), alu_word(0, ALU_ADD, 2'b00));
        write_check("LDA zp", 8'hA5, reg_word(1'b1, REG_A, REG_Z), alu_word(0, ALU_ADD, 2'b00));
        write_check("LDA (zp),Y", 8'hB1, reg_word(1'b1, REG_A, REG_Z), alu_word(0, ALU_ADD, 2'b00));
        write_check("DEX", 8'hCA, reg_word(1'b1, REG_X, REG_X), alu_word(0, ALU_DEC, 2'b00));
        write_check("INX", 8'hE8, reg_word(1'b1, REG_X, REG_X), alu_word(0, ALU_INC, 2'b01));
        no_write_check("JMP abs", 8'h4C);
        no_write_check("ASL zp", 8'h06);
    endtask

    task automatic jsr_stack_writes();
        int cycles;
        feed_opcode(8'h20, -1, cycles);
        expect_equal("JSR length", 5, cycles);
        if (trace.size() >= 4) begin
            for (int k = 0; k < trace.size(); k++)
                expect_equal($sformatf("JSR we cycle %0d", k), (k == 2 || k == 3), trace[k].we);
            expect_equal("JSR do_op PCH", DO_PCH, trace[2].do_op);
            expect_equal("JSR do_op PCL", DO_PCL, trace[3].do_op);
            expect_equal("JSR0 alu_op", alu_word(0, ALU_DEC, 2'b00), trace[1].alu_op);
            expect_equal("JSR1 alu_op", alu_word(0, ALU_DEC, 2'b00), trace[2].alu_op);
        end
    endtask

    task automatic branch_direction();
        int cycles;
        for (int c = 0; c < 2; c++) begin
            for (int b = 0; b < 2; b++) begin
                cond = c[0];
                feed_opcode(8'h80, b, cycles);        // Offset sign forced to b
                expect_equal($sformatf("BRA length cond %0d db7 %0d", c, b), 2, cycles);
                if (trace.size() > 1)
                    expect_equal($sformatf("BRA ab_op cond %0d db7 %0d", c, b),
                                 ab_word((c && b) ? 7'b011_0111 : 7'b011_0110, 2'b11, AB_BRANCH),
                                 trace[1].ab_op);
            end
        end
        cond = 1'b0;
    endtask

    task automatic index_check(input string name, input logic [7:0] op, input int k,
                               input reg_idx_e idx);
        int cycles;
        feed_opcode(op, -1, cycles);
        assert (trace.size() > k) else begin
            errors++;
            $display("%s ended after %0d cycles, before its addressing cycle", name, cycles);
        end
        if (trace.size() > k) begin
            expect_equal(name, {3'b000, idx}, trace[k].reg_op);  // Read only without write
        end
    endtask

    task automatic index_selects();
        index_check("LDA zp,X", 8'hB5, 1, REG_X);
        index_check("LDX zp,Y", 8'hB6, 1, REG_Y);
        index_check("LDA abs,X", 8'hBD, 2, REG_X);
        index_check("LDA abs,Y", 8'hB9, 2, REG_Y);
        index_check("LDA (zp,X)", 8'hA1, 1, REG_X);
        index_check("LDA (zp),Y", 8'hB1, 3, REG_Y);
        index_check("JMP (abs,X) first ABS1", 8'h7C, 2, REG_X);
        if (trace.size() > 4)
            expect_equal("JMP (abs,X) second ABS1", {3'b000, REG_Z}, trace[4].reg_op);
        index_check("JMP abs after (abs,X)", 8'h4C, 2, REG_Z);
    endtask

    initial begin
        rst_n = 1'b0;
        db    = '0;
        cond  = 1'b0;
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        reset_start();
        instruction_lengths();
        register_writes();
        jsr_stack_writes();
        branch_direction();
        index_selects();
        assert_failures = cpu_ctl_inst.cpu_ctl_assert_inst.failures;
        $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
cpu_ctl_pkg.sv
opcode_decoder.sv
ctl_sequencer.sv
ctl_encoder.sv
cpu_ctl.sv
cpu_ctl_assert.sv
cpu_ctl_tb.sv
